//--- sources.f
verilog/test_pattern_pkg.sv
verilog/video_timing.sv
verilog/square_motion.sv
verilog/square_overlay.sv
verilog/i2s_serializer.sv
verilog/test_pattern_top.sv
bench/tb_test_pattern.sv

//--- Makefile
VERILATOR  = verilator
FILE_LIST  = sources.f
TOP        = tb_test_pattern
RTL_TOP    = test_pattern_top
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
FAIL_MSG   = Done: errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_test_pattern.sv
////////////////////
// test pattern core testbench
// small raster, random i2s samples, self checking
// raster, picture, motion and audio framing
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_test_pattern;

    // small raster so that frames are short
    localparam int H_TOTAL       = 40;
    localparam int H_ACTIVE      = 24;
    localparam int V_TOTAL       = 30;
    localparam int V_ACTIVE      = 20;
    localparam int SQUARE_SIZE   = 3;
    localparam int SQUARE_X_INIT = 5;
    localparam int SQUARE_Y_INIT = 5;
    localparam int X_LIMIT       = H_ACTIVE - SQUARE_SIZE;
    localparam int Y_LIMIT       = V_ACTIVE - SQUARE_SIZE;
    localparam int CLK_PERIOD    = 4;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int FRAMES_TO_CHECK = 10;
    // two spare frames plus reset margin
    localparam int WATCHDOG_NS   = ((FRAMES_TO_CHECK + 2) * FRAME_CYCLES + 100) * CLK_PERIOD;
    // i2s framing
    localparam int SCLK_PERIOD   = 4;
    localparam int LRCK_HALF     = 128;
    localparam int SLOT_BITS     = 32;
    localparam int SAMPLE_BITS   = 16;
    localparam logic [23:0] GREY  = {3{8'd60}};
    localparam logic [23:0] BLACK = 24'h000000;

    logic                      audgen_mclk;
    logic                      reset_n;
    test_pattern_pkg::sample_t audio_left;
    test_pattern_pkg::sample_t audio_right;
    test_pattern_pkg::rgb_t    video_rgb;
    logic                      video_de;
    logic                      video_hs;
    logic                      video_vs;
    logic                      audio_sclk;
    logic                      audio_lrck;
    logic                      audio_dac;

    int mismatch_count = 0;
    int other_errors   = 0;
    int frames_done    = 0;
    logic [15:0] lfsr_state;

    test_pattern_top #(
        .H_TOTAL       (H_TOTAL),
        .H_ACTIVE      (H_ACTIVE),
        .H_BPORCH      (2),
        .V_TOTAL       (V_TOTAL),
        .V_ACTIVE      (V_ACTIVE),
        .V_BPORCH      (2),
        .SQUARE_SIZE   (SQUARE_SIZE),
        .SQUARE_X_INIT (SQUARE_X_INIT),
        .SQUARE_Y_INIT (SQUARE_Y_INIT)
    ) test_pattern_top_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    always #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        mismatch_count++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    endtask

    ////////////////////
    // random samples
    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int nbits, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    task automatic next_samples();
        logic [15:0] value;
        take_bits(SAMPLE_BITS, value);
        audio_left = value;
        take_bits(SAMPLE_BITS, value);
        audio_right = value;
    endtask

    ////////////////////
    // main sequence
    initial begin
        audgen_mclk = 1'b0;
        reset_n     = 1'b0;
        lfsr_state  = 16'd24;
        next_samples();
        repeat (5) @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        reset_n = 1'b1;
        wait (frames_done >= FRAMES_TO_CHECK);
        repeat (4) @(posedge audgen_mclk);
        print_summary();
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before %0d frames were checked", FRAMES_TO_CHECK);
        other_errors++;
        print_summary();
        $display("Done: errors found");
        $finish;
    end

    ////////////////////
    // raster timing
    int hs_gap;
    int vs_gap;
    int vs_age;
    bit hs_seen = 1'b0;
    bit vs_seen = 1'b0;
    bit hs_pending = 1'b0;

    always @(posedge audgen_mclk) begin
        if (reset_n) begin
            hs_gap++;
            vs_gap++;
            vs_age++;
            if (video_hs) begin
                if (hs_seen) begin
                    assert (hs_gap == H_TOTAL)
                        else report_mismatch($sformatf("hs spacing %0d", hs_gap));
                end
                // first hs of the frame sits 3 cycles after vs
                if (hs_pending) begin
                    assert (vs_age == 3)
                        else report_mismatch($sformatf("hs %0d cycles after vs", vs_age));
                    hs_pending = 1'b0;
                end
                hs_seen = 1'b1;
                hs_gap  = 0;
            end
            if (video_vs) begin
                if (vs_seen) begin
                    assert (vs_gap == FRAME_CYCLES)
                        else report_mismatch($sformatf("vs spacing %0d", vs_gap));
                end
                vs_seen    = 1'b1;
                vs_gap     = 0;
                vs_age     = 0;
                hs_pending = 1'b1;
            end
        end
    end

    // no colour outside the active window
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video_de |-> video_rgb == BLACK)
        else report_mismatch("video_rgb not black while DE is low");

    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_hs |-> !video_vs)
        else report_mismatch("hs and vs in the same cycle");

    ////////////////////
    // picture and motion
    int  col;
    int  de_lines;
    int  black_count;
    int  min_col;
    int  max_col;
    int  min_row;
    int  max_row;
    int  corner_x;
    int  corner_y;
    int  step_x;
    int  step_y;
    bit  de_prev = 1'b0;
    bit  frame_open = 1'b0;

    task automatic close_frame();
        int cx;
        int cy;
        int dx;
        int dy;
        assert (de_lines == V_ACTIVE)
            else report_mismatch($sformatf("%0d DE lines in frame", de_lines));
        assert (black_count == SQUARE_SIZE * SQUARE_SIZE)
            else report_mismatch($sformatf("%0d black pixels in frame", black_count));
        // 9 pixels inside a 3x3 box means one solid block
        assert (max_col - min_col + 1 == SQUARE_SIZE && max_row - min_row + 1 == SQUARE_SIZE)
            else report_mismatch("black pixels do not form one square");
        cx = min_col;
        cy = min_row;
        frames_done++;
        if (frames_done == 1) begin
            assert (cx == SQUARE_X_INIT && cy == SQUARE_Y_INIT)
                else report_mismatch($sformatf("first corner (%0d,%0d)", cx, cy));
        end else if (frames_done == 2) begin
            assert (cx == SQUARE_X_INIT - 1 && cy == SQUARE_Y_INIT + 1)
                else report_mismatch($sformatf("second corner (%0d,%0d)", cx, cy));
        end
        if (frames_done >= 2) begin
            dx = cx - corner_x;
            dy = cy - corner_y;
            assert ((dx == 1 || dx == -1) && (dy == 1 || dy == -1))
                else report_mismatch($sformatf("corner step (%0d,%0d)", dx, dy));
            // reversal only at an edge of the visible area
            if (frames_done >= 3) begin
                assert ((dx != step_x) == (corner_x == 0 || corner_x == X_LIMIT))
                    else report_mismatch($sformatf("x bounce wrong at x=%0d", corner_x));
                assert ((dy != step_y) == (corner_y == 0 || corner_y == Y_LIMIT))
                    else report_mismatch($sformatf("y bounce wrong at y=%0d", corner_y));
            end
            step_x = dx;
            step_y = dy;
        end
        corner_x = cx;
        corner_y = cy;
    endtask

    always @(posedge audgen_mclk) begin
        if (reset_n) begin
            if (video_vs) begin
                if (frame_open) begin
                    close_frame();
                end
                frame_open  = 1'b1;
                de_lines    = 0;
                black_count = 0;
                min_col     = H_ACTIVE;
                max_col     = -1;
                min_row     = V_ACTIVE;
                max_row     = -1;
            end
            if (video_de) begin
                if (!de_prev) begin
                    col = 0;
                end
                assert (video_rgb == GREY || video_rgb == BLACK)
                    else report_mismatch($sformatf("pixel colour %06h", video_rgb));
                if (video_rgb == BLACK) begin
                    black_count++;
                    if (col < min_col) begin
                        min_col = col;
                    end
                    if (col > max_col) begin
                        max_col = col;
                    end
                    if (de_lines < min_row) begin
                        min_row = de_lines;
                    end
                    if (de_lines > max_row) begin
                        max_row = de_lines;
                    end
                end
                col++;
            end else if (de_prev) begin
                assert (col == H_ACTIVE)
                    else report_mismatch($sformatf("%0d DE cycles in line", col));
                de_lines++;
            end
            de_prev = video_de;
        end
    end

    ////////////////////
    // i2s stimulus and checks
    logic [15:0] exp_sample;
    logic        exp_bit;
    logic        lrck_drv = 1'b0;
    logic        sclk_prev = 1'b0;
    logic        lrck_prev = 1'b0;
    bit          sclk_seen = 1'b0;
    bit          lrck_seen = 1'b0;
    bit          slot_valid = 1'b0;
    int          sclk_age;
    int          lrck_age;
    int          bit_index;

    // latched sample is the port value held across the lrck edge
    always @(negedge audgen_mclk) begin
        if (reset_n && audio_lrck != lrck_drv) begin
            exp_sample = audio_lrck ? audio_right : audio_left;
            // new pair once per lrck period away from both latch points
            if (audio_lrck) begin
                next_samples();
            end
            lrck_drv = audio_lrck;
        end
    end

    always @(posedge audgen_mclk) begin
        if (reset_n) begin
            sclk_age++;
            lrck_age++;
            if (audio_sclk && !sclk_prev) begin
                if (sclk_seen) begin
                    assert (sclk_age == SCLK_PERIOD)
                        else report_mismatch($sformatf("sclk period %0d", sclk_age));
                end
                sclk_seen = 1'b1;
                sclk_age  = 0;
                // the receiver samples on the rising edge
                if (slot_valid) begin
                    exp_bit = (bit_index < SAMPLE_BITS) ? exp_sample[15 - bit_index] : 1'b0;
                    assert (audio_dac == exp_bit)
                        else report_mismatch($sformatf("dac bit %0d is %0b, expected %0b",
                                                       bit_index, audio_dac, exp_bit));
                    bit_index++;
                end
            end
            if (!audio_sclk && sclk_prev) begin
                assert (sclk_age == SCLK_PERIOD / 2)
                    else report_mismatch($sformatf("sclk high for %0d cycles", sclk_age));
            end
            if (audio_lrck != lrck_prev) begin
                if (lrck_seen) begin
                    assert (lrck_age == LRCK_HALF)
                        else report_mismatch($sformatf("lrck half period %0d", lrck_age));
                    assert (bit_index == SLOT_BITS)
                        else report_mismatch($sformatf("%0d bits in slot", bit_index));
                end
                lrck_seen  = 1'b1;
                lrck_age   = 0;
                slot_valid = 1'b1;
                bit_index  = 0;
            end
            sclk_prev = audio_sclk;
            lrck_prev = audio_lrck;
        end
    end

    // lrck moves with the falling sclk edge
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk))
        else report_mismatch("lrck changed away from an sclk falling edge");

endmodule

`default_nettype wire

//--- verilog/test_pattern_top.sv
////////////////////
// test pattern core top level
// grey field with a bouncing square on the video
// port and an i2s stream of the sample inputs
////////////////////

`timescale 1ns/1ns
`default_nettype none

module test_pattern_top #(
    parameter int H_TOTAL       = 400,
    parameter int H_ACTIVE      = 320,
    parameter int H_BPORCH      = 10,
    parameter int V_TOTAL       = 512,
    parameter int V_ACTIVE      = 240,
    parameter int V_BPORCH      = 10,
    parameter int SQUARE_SIZE   = 15,
    parameter int SQUARE_X_INIT = 135,
    parameter int SQUARE_Y_INIT = 95
) (
    input  wire                            audgen_mclk,
    input  wire                            reset_n,
    input  wire test_pattern_pkg::sample_t audio_left,
    input  wire test_pattern_pkg::sample_t audio_right,
    output test_pattern_pkg::rgb_t         video_rgb,
    output logic                           video_de,
    output logic                           video_hs,
    output logic                           video_vs,
    output logic                           audio_sclk,
    output logic                           audio_lrck,
    output logic                           audio_dac
);

    // raster stage to overlay and motion
    logic                     line_de;
    logic                     line_hs;
    logic                     line_vs;
    logic                     frame_start;
    test_pattern_pkg::coord_t vis_x;
    test_pattern_pkg::coord_t vis_y;
    // square corner
    test_pattern_pkg::coord_t square_x;
    test_pattern_pkg::coord_t square_y;

    ////////////////////
    // video path
    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_BPORCH (V_BPORCH)
    ) video_timing_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .line_de     (line_de),
        .line_hs     (line_hs),
        .line_vs     (line_vs),
        .frame_start (frame_start),
        .vis_x       (vis_x),
        .vis_y       (vis_y)
    );

    square_motion #(
        .H_ACTIVE      (H_ACTIVE),
        .V_ACTIVE      (V_ACTIVE),
        .SQUARE_SIZE   (SQUARE_SIZE),
        .SQUARE_X_INIT (SQUARE_X_INIT),
        .SQUARE_Y_INIT (SQUARE_Y_INIT)
    ) square_motion_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .square_x    (square_x),
        .square_y    (square_y)
    );

    square_overlay #(
        .SQUARE_SIZE (SQUARE_SIZE)
    ) square_overlay_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .line_de     (line_de),
        .line_hs     (line_hs),
        .line_vs     (line_vs),
        .vis_x       (vis_x),
        .vis_y       (vis_y),
        .square_x    (square_x),
        .square_y    (square_y),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

    ////////////////////
    // audio path
    i2s_serializer i2s_serializer_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

`default_nettype wire

//--- verilog/i2s_serializer.sv
////////////////////
// i2s serializer
// sclk at mclk/4, 32 bit slots per channel,
// 16 sample bits msb first then zero padding
////////////////////

`timescale 1ns/1ns
`default_nettype none

module i2s_serializer (
    input  wire                            audgen_mclk,
    input  wire                            reset_n,
    input  wire test_pattern_pkg::sample_t audio_left,
    input  wire test_pattern_pkg::sample_t audio_right,
    output logic                           audio_sclk,
    output logic                           audio_lrck,
    output logic                           audio_dac
);

    localparam int DIV_W    = $clog2(test_pattern_pkg::SCLK_DIV);
    localparam int CNT_W    = $clog2(test_pattern_pkg::BITS_PER_CHANNEL);
    localparam int SAMPLE_W = $bits(test_pattern_pkg::sample_t);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(test_pattern_pkg::SCLK_DIV - 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(test_pattern_pkg::BITS_PER_CHANNEL - 1);
    localparam logic [CNT_W-1:0] PAD_FIRST = CNT_W'(SAMPLE_W);

    logic [DIV_W-1:0]           mclk_div;
    logic                       sclk_fall;
    // index of the bit now on the dac line
    logic [CNT_W-1:0]           bit_cnt;
    test_pattern_pkg::channel_t channel;
    test_pattern_pkg::channel_t channel_next;
    test_pattern_pkg::sample_t  sample_next;
    logic [SAMPLE_W-1:0]        shift_reg;

    ////////////////////
    // sclk divider
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
        end
    end

    // low for the first half, high for the second
    assign audio_sclk = mclk_div[DIV_W-1];
    // cycle where sclk is about to fall
    assign sclk_fall  = (mclk_div == DIV_LAST);

    // channel and sample of the coming slot
    assign channel_next = (channel == test_pattern_pkg::CH_LEFT) ?
                          test_pattern_pkg::CH_RIGHT : test_pattern_pkg::CH_LEFT;
    assign sample_next  = (channel_next == test_pattern_pkg::CH_RIGHT) ? audio_right : audio_left;

    ////////////////////
    // slot counter and shifter
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt   <= '0;
            channel   <= test_pattern_pkg::CH_LEFT;
            shift_reg <= '0;
            audio_dac <= 1'b0;
        end else if (sclk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST) begin
                // switch channel and send the msb with the lrck edge
                channel   <= channel_next;
                audio_dac <= sample_next[SAMPLE_W-1];
                shift_reg <= {sample_next[SAMPLE_W-2:0], 1'b0};
            end else begin
                // zeros fill in once the sample is out
                audio_dac <= shift_reg[SAMPLE_W-1];
                shift_reg <= {shift_reg[SAMPLE_W-2:0], 1'b0};
            end
        end
    end

    assign audio_lrck = (channel == test_pattern_pkg::CH_RIGHT);

    // padding half of every slot is silent
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (bit_cnt >= PAD_FIRST) |-> !audio_dac);

endmodule

`default_nettype wire

//--- verilog/square_overlay.sv
////////////////////
// square overlay
// colours each pixel grey or black and registers
// colour with the syncs so they stay aligned
////////////////////

`timescale 1ns/1ns
`default_nettype none

module square_overlay #(
    parameter int SQUARE_SIZE = 15
) (
    input  wire                      audgen_mclk,
    input  wire                      reset_n,
    input  wire                      line_de,
    input  wire                      line_hs,
    input  wire                      line_vs,
    input  wire test_pattern_pkg::coord_t vis_x,
    input  wire test_pattern_pkg::coord_t vis_y,
    input  wire test_pattern_pkg::coord_t square_x,
    input  wire test_pattern_pkg::coord_t square_y,
    output test_pattern_pkg::rgb_t   video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    localparam test_pattern_pkg::coord_t SIZE = test_pattern_pkg::coord_t'(SQUARE_SIZE);
    // same level on all three channels
    localparam test_pattern_pkg::rgb_t GREY = {3{test_pattern_pkg::GREY_LEVEL}};

    logic                   in_square_x;
    logic                   in_square_y;
    test_pattern_pkg::rgb_t pixel_rgb;

    // corner is inclusive and the far edge exclusive
    assign in_square_x = (vis_x >= square_x) && (vis_x < square_x + SIZE);
    assign in_square_y = (vis_y >= square_y) && (vis_y < square_y + SIZE);

    ////////////////////
    // colour rule
    always_comb begin
        // black outside the active window
        pixel_rgb = '0;
        if (line_de && !(in_square_x && in_square_y)) begin
            pixel_rgb = GREY;
        end
    end

    ////////////////////
    // output stage
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= pixel_rgb;
            video_de  <= line_de;
            video_hs  <= line_hs;
            video_vs  <= line_vs;
        end
    end

endmodule

`default_nettype wire

//--- verilog/square_motion.sv
////////////////////
// bouncing square position
// steps one pixel per axis on each frame strobe
// and reverses at the edges of the visible area
////////////////////

`timescale 1ns/1ns
`default_nettype none

module square_motion #(
    parameter int H_ACTIVE      = 320,
    parameter int V_ACTIVE      = 240,
    parameter int SQUARE_SIZE   = 15,
    parameter int SQUARE_X_INIT = 135,
    parameter int SQUARE_Y_INIT = 95
) (
    input  wire                      audgen_mclk,
    input  wire                      reset_n,
    input  wire                      frame_start,
    output test_pattern_pkg::coord_t square_x,
    output test_pattern_pkg::coord_t square_y
);

    // largest corner that keeps the square visible
    localparam test_pattern_pkg::coord_t X_MAX  = test_pattern_pkg::coord_t'(H_ACTIVE - SQUARE_SIZE);
    localparam test_pattern_pkg::coord_t Y_MAX  = test_pattern_pkg::coord_t'(V_ACTIVE - SQUARE_SIZE);
    localparam test_pattern_pkg::coord_t X_INIT = test_pattern_pkg::coord_t'(SQUARE_X_INIT);
    localparam test_pattern_pkg::coord_t Y_INIT = test_pattern_pkg::coord_t'(SQUARE_Y_INIT);

    test_pattern_pkg::dir_t dir_x;
    test_pattern_pkg::dir_t dir_y;
    test_pattern_pkg::dir_t dir_x_next;
    test_pattern_pkg::dir_t dir_y_next;
    // reset position is held through the first frame
    logic                   first_frame;

    ////////////////////
    // bounce decision
    always_comb begin
        dir_x_next = dir_x;
        if (square_x == '0 && dir_x == test_pattern_pkg::DIR_NEG) begin
            dir_x_next = test_pattern_pkg::DIR_POS;
        end else if (square_x == X_MAX && dir_x == test_pattern_pkg::DIR_POS) begin
            dir_x_next = test_pattern_pkg::DIR_NEG;
        end
        dir_y_next = dir_y;
        if (square_y == '0 && dir_y == test_pattern_pkg::DIR_NEG) begin
            dir_y_next = test_pattern_pkg::DIR_POS;
        end else if (square_y == Y_MAX && dir_y == test_pattern_pkg::DIR_POS) begin
            dir_y_next = test_pattern_pkg::DIR_NEG;
        end
    end

    ////////////////////
    // position and direction
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            square_x    <= X_INIT;
            square_y    <= Y_INIT;
            dir_x       <= test_pattern_pkg::DIR_NEG;
            dir_y       <= test_pattern_pkg::DIR_POS;
            first_frame <= 1'b1;
        end else if (frame_start) begin
            first_frame <= 1'b0;
            if (!first_frame) begin
                dir_x <= dir_x_next;
                dir_y <= dir_y_next;
                // flip first and then step in the new direction
                square_x <= (dir_x_next == test_pattern_pkg::DIR_POS) ?
                            square_x + 1'b1 : square_x - 1'b1;
                square_y <= (dir_y_next == test_pattern_pkg::DIR_POS) ?
                            square_y + 1'b1 : square_y - 1'b1;
            end
        end
    end

    // whole square stays on screen
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        square_x <= X_MAX && square_y <= Y_MAX);

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
////////////////////
// video raster timing
// free running line and frame counters with registered
// sync pulses, data enable and visible coordinates
////////////////////

`timescale 1ns/1ns
`default_nettype none

module video_timing #(
    parameter int H_TOTAL  = 400,
    parameter int H_ACTIVE = 320,
    parameter int H_BPORCH = 10,
    parameter int V_TOTAL  = 512,
    parameter int V_ACTIVE = 240,
    parameter int V_BPORCH = 10
) (
    input  wire                      audgen_mclk,
    input  wire                      reset_n,
    output logic                     line_de,
    output logic                     line_hs,
    output logic                     line_vs,
    output logic                     frame_start,
    output test_pattern_pkg::coord_t vis_x,
    output test_pattern_pkg::coord_t vis_y
);

    // counter limits and window edges
    localparam test_pattern_pkg::coord_t H_LAST  = test_pattern_pkg::coord_t'(H_TOTAL - 1);
    localparam test_pattern_pkg::coord_t V_LAST  = test_pattern_pkg::coord_t'(V_TOTAL - 1);
    localparam test_pattern_pkg::coord_t H_START = test_pattern_pkg::coord_t'(H_BPORCH);
    localparam test_pattern_pkg::coord_t V_START = test_pattern_pkg::coord_t'(V_BPORCH);
    localparam test_pattern_pkg::coord_t H_END   = test_pattern_pkg::coord_t'(H_BPORCH + H_ACTIVE);
    localparam test_pattern_pkg::coord_t V_END   = test_pattern_pkg::coord_t'(V_BPORCH + V_ACTIVE);
    // hs lands a few cycles after vs
    localparam test_pattern_pkg::coord_t HS_POS  = test_pattern_pkg::coord_t'(3);

    test_pattern_pkg::coord_t h_count;
    test_pattern_pkg::coord_t v_count;
    logic                     h_last;
    logic                     v_last;
    logic                     h_window;
    logic                     v_window;

    assign h_last   = (h_count == H_LAST);
    assign v_last   = (v_count == V_LAST);
    // back porch plus active region
    assign h_window = (h_count >= H_START) && (h_count < H_END);
    assign v_window = (v_count >= V_START) && (v_count < V_END);

    ////////////////////
    // raster counters
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
            if (h_last) begin
                h_count <= '0;
                // next line, wrap at end of frame
                if (v_last) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // registered decode
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            line_de <= 1'b0;
            line_hs <= 1'b0;
            line_vs <= 1'b0;
        end else begin
            // new frame at the very first count
            line_vs <= (h_count == '0) && (v_count == '0);
            line_hs <= (h_count == HS_POS);
            line_de <= h_window && v_window;
        end
    end

    // coordinates relative to the visible area
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            vis_x <= '0;
            vis_y <= '0;
        end else begin
            vis_x <= h_count - H_START;
            vis_y <= v_count - V_START;
        end
    end

    // motion logic steps on the vs pulse
    assign frame_start = line_vs;

    // hs follows vs by exactly 3 cycles and never shares its cycle
    assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        line_vs |-> !line_hs [*3] ##1 line_hs);

endmodule

`default_nettype wire

//--- verilog/test_pattern_pkg.sv
////////////////////
// test pattern shared definitions
// pixel, coordinate and sample types plus
// the fixed grey level and i2s framing constants
////////////////////

`default_nettype none

package test_pattern_pkg;

    ////////////////////
    // video types

    // raster or screen coordinate
    typedef logic [9:0] coord_t;

    // 8 bits per channel with red in the top byte
    typedef logic [23:0] rgb_t;

    // square direction on one axis
    typedef enum logic {
        DIR_NEG = 1'b0,
        DIR_POS = 1'b1
    } dir_t;

    // background level per channel
    localparam logic [7:0] GREY_LEVEL = 8'd60;

    ////////////////////
    // audio types

    // two's complement pcm sample
    typedef logic signed [15:0] sample_t;

    // i2s channel that follows the lrck level
    typedef enum logic {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_t;

    // sclk periods per lrck half period
    localparam int BITS_PER_CHANNEL = 32;

    // mclk cycles per sclk period
    localparam int SCLK_DIV = 4;

endpackage

`default_nettype wire
